//--- src/noc_config_pkg.sv
package noc_config_pkg;

  // ------------------------------
  // mesh geometry
  // ------------------------------
  localparam int coord_width = 2; // bits per coordinate.
  localparam int size_x = 3; // columns, x in 0..2.
  localparam int size_y = 3; // rows, y in 0..2.

  // ------------------------------
  // packet fields
  // ------------------------------
  localparam int burst_width = 4; // burst length field.
  localparam int data_width = 32; // one flit data word.

  // ------------------------------
  // error response
  // ------------------------------
  // data word returned for every beat of a failed read.
  localparam logic [data_width-1:0] error_data = 32'hDEAD_BEEF;

endpackage

//--- src/noc_flit_pkg.sv
package noc_flit_pkg;

  // ------------------------------
  // packet types and status
  // ------------------------------
  typedef enum logic [1:0] {
    packet_read = 2'd0, // non-posted, no payload.
    packet_write = 2'd1, // non-posted, with payload.
    packet_response = 2'd2, // posted, no payload.
    packet_response_with_data = 2'd3 // posted, with payload.
  } packet_type_e;

  typedef enum logic [1:0] {
    status_okay = 2'd0,
    status_decode_error = 2'd1
  } status_e;

  // ------------------------------
  // header and payload
  // ------------------------------
  typedef struct packed {
    logic [noc_config_pkg::coord_width-1:0] y;
    logic [noc_config_pkg::coord_width-1:0] x;
  } location_t;

  typedef struct packed {
    packet_type_e packet_type;
    location_t destination;
    location_t source;
    logic [3:0] tag;
    logic [noc_config_pkg::burst_width-1:0] burst_length; // beats, reads and writes.
    status_e status;
    logic invalid_destination; // set by the sender.
    logic [10:0] padding; // fills the word to 32 bits.
  } header_t;

  typedef struct packed {
    logic [noc_config_pkg::data_width-1:0] data;
  } payload_t;

  // the same word seen as a header on a head flit, as data otherwise.
  typedef union packed {
    header_t header;
    payload_t payload;
  } flit_data_u;

  // ------------------------------
  // flit
  // ------------------------------
  typedef struct packed {
    logic head;
    logic tail;
    flit_data_u data;
  } flit_t;

endpackage

//--- src/noc_packet_steer.sv
module noc_packet_steer (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  noc_flit_pkg::flit_t in_flit,
  output logic                in_ready,
  output logic                pass_valid,
  output noc_flit_pkg::flit_t pass_flit,
  input  logic                pass_ready,
  output logic                err_valid,
  output noc_flit_pkg::flit_t err_flit,
  input  logic                err_ready,
  input  logic                busy
);

  // ------------------------------
  // destination check
  // ------------------------------
  noc_flit_pkg::header_t head_hdr;
  logic                  head_invalid;

  assign head_hdr = in_flit.data.header; // only meaningful on a head.

  always_comb begin
    head_invalid = 1'b0;
    if (head_hdr.invalid_destination) begin
      head_invalid = 1'b1;
    end
    if (head_hdr.destination.x >= noc_config_pkg::size_x) begin
      head_invalid = 1'b1;
    end
    if (head_hdr.destination.y >= noc_config_pkg::size_y) begin
      head_invalid = 1'b1;
    end
  end

  // ------------------------------
  // route selection
  // ------------------------------
  logic route_err_q; // 0 normal, 1 error.
  logic route_err;
  logic head_hold;
  logic head_accept;

  // a new packet waits until the responder is idle.
  assign head_hold = in_flit.head && busy;

  assign route_err = in_flit.head ? head_invalid : route_err_q;

  assign head_accept = in_valid && in_ready && in_flit.head;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      route_err_q <= 1'b0;
    end else if (head_accept) begin
      route_err_q <= head_invalid; // held to the tail.
    end
  end

  // ------------------------------
  // demultiplex
  // ------------------------------
  assign pass_valid = in_valid && !head_hold && !route_err;
  assign err_valid = in_valid && !head_hold && route_err;

  assign pass_flit = in_flit;
  assign err_flit = in_flit;

  always_comb begin
    if (head_hold) begin
      in_ready = 1'b0;
    end else if (route_err) begin
      in_ready = err_ready;
    end else begin
      in_ready = pass_ready;
    end
  end

  // ------------------------------
  // checks
  // ------------------------------
  // the responder only works behind an error head.
  assert property (@(posedge clk) disable iff (!rst_n)
    busy |-> route_err_q)
    else $error("responder busy on a normal route");

endmodule

//--- src/noc_error_responder.sv
module noc_error_responder (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_valid,
  input  noc_flit_pkg::flit_t req_flit,
  output logic                req_ready,
  output logic                rsp_valid,
  output noc_flit_pkg::flit_t rsp_flit,
  input  logic                rsp_ready,
  output logic                busy
);

  // ------------------------------
  // request side
  // ------------------------------
  noc_flit_pkg::header_t                  req_hdr_q;
  noc_flit_pkg::header_t                  cur_hdr;
  logic [noc_config_pkg::burst_width-1:0] beat_count;
  logic                                   consuming;
  logic                                   rsp_head_phase;
  logic                                   req_fire;
  logic                                   req_head_fire;
  logic                                   req_tail_fire;
  logic                                   need_rsp;
  logic                                   rsp_fire;
  logic                                   is_read;

  assign req_ready = !rsp_valid; // drain the request until its tail.
  assign req_fire = req_valid && req_ready;
  assign req_head_fire = req_fire && req_flit.head;
  assign req_tail_fire = req_fire && req_flit.tail;

  // a single-flit request has not been latched yet at its tail.
  assign cur_hdr = req_flit.head ? req_flit.data.header : req_hdr_q;

  assign need_rsp = (cur_hdr.packet_type == noc_flit_pkg::packet_read) ||
                    (cur_hdr.packet_type == noc_flit_pkg::packet_write);

  always_ff @(posedge clk) begin
    if (req_head_fire) begin
      req_hdr_q <= req_flit.data.header;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      consuming <= 1'b0;
    end else if (req_fire) begin
      consuming <= !req_flit.tail;
    end
  end

  // ------------------------------
  // response sequencing
  // ------------------------------
  assign rsp_fire = rsp_valid && rsp_ready;
  assign is_read = (req_hdr_q.packet_type == noc_flit_pkg::packet_read);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
      rsp_head_phase <= 1'b0;
    end else if (req_tail_fire && need_rsp) begin
      rsp_valid <= 1'b1; // offered once the request is gone.
      rsp_head_phase <= 1'b1;
    end else if (rsp_fire) begin
      rsp_head_phase <= 1'b0;
      if (rsp_flit.tail) begin
        rsp_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_count <= '0;
    end else if (req_head_fire) begin
      if (req_flit.data.header.packet_type == noc_flit_pkg::packet_read) begin
        beat_count <= req_flit.data.header.burst_length;
      end else begin
        beat_count <= '0; // writes answer with a header only.
      end
    end else if (rsp_fire && !rsp_head_phase) begin
      beat_count <= beat_count - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
    end else if (req_head_fire) begin
      busy <= 1'b1;
    end else if (req_tail_fire && !need_rsp) begin
      busy <= 1'b0; // posted, dropped silently.
    end else if (rsp_fire && rsp_flit.tail) begin
      busy <= 1'b0;
    end else if (!consuming && !rsp_valid) begin
      busy <= 1'b0; // single-flit posted request.
    end
  end

  // ------------------------------
  // response flit
  // ------------------------------
  noc_flit_pkg::header_t rsp_hdr;

  always_comb begin
    rsp_hdr = '0;
    if (is_read) begin
      rsp_hdr.packet_type = noc_flit_pkg::packet_response_with_data;
      rsp_hdr.burst_length = req_hdr_q.burst_length;
    end else begin
      rsp_hdr.packet_type = noc_flit_pkg::packet_response;
    end
    rsp_hdr.destination = req_hdr_q.source; // back to the sender.
    rsp_hdr.source = req_hdr_q.destination;
    rsp_hdr.tag = req_hdr_q.tag;
    rsp_hdr.status = noc_flit_pkg::status_decode_error;
  end

  always_comb begin
    rsp_flit = '0;
    if (rsp_head_phase) begin
      rsp_flit.head = 1'b1;
      rsp_flit.tail = (beat_count == '0);
      rsp_flit.data.header = rsp_hdr;
    end else begin
      rsp_flit.tail = (beat_count == 1);
      rsp_flit.data.payload.data = noc_config_pkg::error_data;
    end
  end

  // ------------------------------
  // checks
  // ------------------------------
  assert property (@(posedge clk) disable iff (!rst_n)
    (rsp_fire && !rsp_head_phase) |-> (beat_count != '0))
    else $error("beat counter decremented at zero");

  assert property (@(posedge clk) disable iff (!rst_n)
    (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_flit)))
    else $error("response valid or flit changed before transfer");

endmodule

//--- src/noc_flit_merger.sv
module noc_flit_merger (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                a_valid,
  input  noc_flit_pkg::flit_t a_flit,
  output logic                a_ready,
  input  logic                b_valid,
  input  noc_flit_pkg::flit_t b_flit,
  output logic                b_ready,
  output logic                out_valid,
  output noc_flit_pkg::flit_t out_flit,
  input  logic                out_ready
);

  // ------------------------------
  // arbitration
  // ------------------------------
  logic                locked;
  logic                lock_src; // 0 a, 1 b.
  logic                sel;
  logic                take;
  logic                sel_valid;
  logic                fire;
  noc_flit_pkg::flit_t sel_flit;

  always_comb begin
    if (locked) begin
      sel = lock_src; // stay on the packet in progress.
    end else begin
      sel = b_valid; // error stream first on a tie.
    end
  end

  assign take = !out_valid || out_ready;
  assign sel_valid = sel ? b_valid : a_valid;
  assign sel_flit = sel ? b_flit : a_flit;
  assign fire = take && sel_valid;

  assign a_ready = take && !sel;
  assign b_ready = take && sel;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      locked <= 1'b0;
      lock_src <= 1'b0;
    end else if (fire) begin
      if (sel_flit.tail) begin
        locked <= 1'b0;
      end else if (sel_flit.head) begin
        locked <= 1'b1;
        lock_src <= sel;
      end
    end
  end

  // ------------------------------
  // output slice
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (fire) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      out_flit <= sel_flit;
    end
  end

  // ------------------------------
  // checks
  // ------------------------------
  // a packet boundary is only crossed by a head.
  assert property (@(posedge clk) disable iff (!rst_n)
    (fire && !locked) |-> sel_flit.head)
    else $error("flit taken between packets is not a head");

endmodule

//--- src/noc_error_checker.sv
module noc_error_checker (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  noc_flit_pkg::flit_t in_flit,
  output logic                in_ready,
  output logic                out_valid,
  output noc_flit_pkg::flit_t out_flit,
  input  logic                out_ready
);

  // ------------------------------
  // internal streams
  // ------------------------------
  logic                pass_valid; // pass-through path.
  noc_flit_pkg::flit_t pass_flit;
  logic                pass_ready;
  logic                err_in_valid;
  noc_flit_pkg::flit_t err_in_flit;
  logic                err_in_ready;
  logic                err_out_valid;
  noc_flit_pkg::flit_t err_out_flit;
  logic                err_out_ready;
  logic                busy;

  noc_packet_steer noc_packet_steer_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_flit    (in_flit),
    .in_ready   (in_ready),
    .pass_valid (pass_valid),
    .pass_flit  (pass_flit),
    .pass_ready (pass_ready),
    .err_valid  (err_in_valid),
    .err_flit   (err_in_flit),
    .err_ready  (err_in_ready),
    .busy       (busy)
  );

  noc_error_responder noc_error_responder_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (err_in_valid),
    .req_flit  (err_in_flit),
    .req_ready (err_in_ready),
    .rsp_valid (err_out_valid),
    .rsp_flit  (err_out_flit),
    .rsp_ready (err_out_ready),
    .busy      (busy)
  );

  noc_flit_merger noc_flit_merger_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .a_valid   (pass_valid),
    .a_flit    (pass_flit),
    .a_ready   (pass_ready),
    .b_valid   (err_out_valid),
    .b_flit    (err_out_flit),
    .b_ready   (err_out_ready),
    .out_valid (out_valid),
    .out_flit  (out_flit),
    .out_ready (out_ready)
  );

endmodule

//--- verification/noc_clock_gen.sv
module noc_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int half_period = 5;
  localparam int reset_cycles = 10;

  initial begin
    clk = 1'b0;
    forever begin
      #half_period clk = ~clk;
    end
  end

  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1; // released away from the active edge.
  end

endmodule

//--- verification/noc_error_checker_tb.sv
module noc_error_checker_tb;

  localparam int packet_count = 300;
  localparam int max_flits = 9; // request plus response, worst case.
  localparam int cycles_per_flit = 8;
  localparam int cycle_limit = packet_count * max_flits * cycles_per_flit;
  localparam int drain_limit = max_flits * cycles_per_flit; // one packet's worth.

  logic                clk;
  logic                rst_n;
  logic                in_valid;
  logic                in_ready;
  logic                out_valid;
  logic                out_ready;
  noc_flit_pkg::flit_t in_flit;
  noc_flit_pkg::flit_t out_flit;

  noc_flit_pkg::flit_t stim_q[$];
  noc_flit_pkg::flit_t exp_q[$];
  noc_flit_pkg::flit_t exp_flit;
  logic [31:0]         lcg_state = 32'd27979;
  logic                in_taken;
  int                  sent_idx = 0;
  int                  cycle_count = 0;
  int                  checked_count = 0;
  int                  header_errors = 0;
  int                  payload_errors = 0;
  int                  framing_errors = 0;
  int                  unexpected_count = 0;
  int                  missing_count = 0;

  noc_clock_gen noc_clock_gen_inst (
    .clk   (clk),
    .rst_n (rst_n)
  );

  noc_error_checker noc_error_checker_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_flit   (in_flit),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_flit  (out_flit),
    .out_ready (out_ready)
  );

  // ------------------------------
  // random numbers
  // ------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int unsigned rand_below(input int unsigned limit);
    logic [31:0] r;
    r = lcg_next();
    return {16'd0, r[31:16]} % limit; // upper bits, the low ones cycle fast.
  endfunction

  // ------------------------------
  // stimulus and model
  // ------------------------------
  task automatic push_error_response(input noc_flit_pkg::header_t req);
    noc_flit_pkg::header_t rsp;
    noc_flit_pkg::flit_t   f;
    int unsigned           i;
    rsp = '0;
    rsp.destination = req.source;
    rsp.source = req.destination;
    rsp.tag = req.tag;
    rsp.status = noc_flit_pkg::status_decode_error;
    f = '0;
    f.head = 1'b1;
    if (req.packet_type == noc_flit_pkg::packet_read) begin
      rsp.packet_type = noc_flit_pkg::packet_response_with_data;
      rsp.burst_length = req.burst_length;
      f.data.header = rsp;
      exp_q.push_back(f);
      for (i = 0; i < {28'd0, req.burst_length}; i++) begin
        f = '0;
        f.tail = (i == {28'd0, req.burst_length} - 1);
        f.data.payload.data = noc_config_pkg::error_data;
        exp_q.push_back(f);
      end
    end else if (req.packet_type == noc_flit_pkg::packet_write) begin
      rsp.packet_type = noc_flit_pkg::packet_response;
      f.tail = 1'b1;
      f.data.header = rsp;
      exp_q.push_back(f);
    end
    // posted packets vanish without a reply.
  endtask

  task automatic build_packet();
    noc_flit_pkg::header_t hdr;
    noc_flit_pkg::flit_t   f;
    int unsigned           beats;
    int unsigned           i;
    logic                  bad_dest;
    hdr = '0;
    hdr.packet_type = noc_flit_pkg::packet_type_e'(2'(rand_below(4)));
    hdr.destination.x = 2'(rand_below(4)); // 3 is off the mesh.
    hdr.destination.y = 2'(rand_below(4));
    hdr.source.x = 2'(rand_below(3));
    hdr.source.y = 2'(rand_below(3));
    hdr.tag = 4'(rand_below(16));
    hdr.burst_length = 4'(1 + rand_below(4));
    hdr.status = noc_flit_pkg::status_okay;
    hdr.invalid_destination = (rand_below(16) == 0);
    hdr.padding = 11'(rand_below(2048));
    bad_dest = hdr.invalid_destination ||
               (int'(hdr.destination.x) >= noc_config_pkg::size_x) ||
               (int'(hdr.destination.y) >= noc_config_pkg::size_y);
    beats = 0;
    if (hdr.packet_type == noc_flit_pkg::packet_write ||
        hdr.packet_type == noc_flit_pkg::packet_response_with_data) begin
      beats = {28'd0, hdr.burst_length};
    end
    f = '0;
    f.head = 1'b1;
    f.tail = (beats == 0);
    f.data.header = hdr;
    stim_q.push_back(f);
    if (!bad_dest) exp_q.push_back(f);
    for (i = 0; i < beats; i++) begin
      f = '0;
      f.tail = (i == beats - 1);
      f.data.payload.data = lcg_next();
      stim_q.push_back(f);
      if (!bad_dest) exp_q.push_back(f);
    end
    if (bad_dest) push_error_response(hdr);
  endtask

  // ------------------------------
  // checks
  // ------------------------------
  task automatic check_header(input noc_flit_pkg::header_t got,
                              input noc_flit_pkg::header_t exp);
    if (got !== exp) begin
      header_errors++;
      $display("FAIL %0t: header mismatch, got %h (type %0d) expected %h (type %0d)",
               $time, got, got.packet_type, exp, exp.packet_type);
    end
  endtask

  task automatic check_payload(input noc_flit_pkg::payload_t got,
                               input noc_flit_pkg::payload_t exp);
    if (got !== exp) begin
      payload_errors++;
      $display("FAIL %0t: payload mismatch, got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_framing(input logic got_head, input logic got_tail,
                               input logic exp_head, input logic exp_tail);
    if (got_head !== exp_head || got_tail !== exp_tail) begin
      framing_errors++;
      $display("FAIL %0t: head/tail mismatch, got %b%b expected %b%b",
               $time, got_head, got_tail, exp_head, exp_tail);
    end
  endtask

  function automatic int total_errors();
    return header_errors + payload_errors + framing_errors + unexpected_count + missing_count;
  endfunction

  task automatic print_counts();
    $display("errors: header %0d, payload %0d, framing %0d, unexpected %0d, missing %0d",
             header_errors, payload_errors, framing_errors, unexpected_count, missing_count);
  endtask

  always @(posedge clk) begin
    in_taken <= in_valid && in_ready;
  end

  always @(posedge clk) begin
    if (rst_n && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        unexpected_count++;
        $display("unexpected output flit %h at time %0t, nothing was expected", out_flit, $time);
      end else begin
        exp_flit = exp_q.pop_front();
        check_framing(out_flit.head, out_flit.tail, exp_flit.head, exp_flit.tail);
        if (exp_flit.head) begin
          check_header(out_flit.data.header, exp_flit.data.header);
        end else begin
          check_payload(out_flit.data.payload, exp_flit.data.payload);
        end
        checked_count++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles, %0d of %0d input flits sent, %0d outputs still due",
               cycle_count, sent_idx, stim_q.size(), exp_q.size());
      print_counts();
      $display(">>> FAIL");
      $finish;
    end
  end

  // ------------------------------
  // main sequence
  // ------------------------------
  task automatic drive_step();
    out_ready = (rand_below(4) != 0); // stall about one cycle in four.
    if (in_valid && in_taken) begin
      sent_idx++;
      in_valid = 1'b0;
    end
    if (!in_valid && sent_idx < stim_q.size() && rand_below(3) != 0) begin
      in_flit = stim_q[sent_idx];
      in_valid = 1'b1;
    end
  endtask

  initial begin
    int p;
    int drain_count;
    in_valid = 1'b0;
    in_flit = '0;
    out_ready = 1'b0;
    for (p = 0; p < packet_count; p++) begin
      build_packet();
    end
    @(posedge rst_n);
    while (sent_idx < stim_q.size()) begin
      @(negedge clk);
      drive_step();
    end
    // let the last responses drain.
    @(negedge clk);
    out_ready = 1'b1;
    drain_count = 0;
    while (exp_q.size() != 0 && drain_count < drain_limit) begin
      @(negedge clk);
      drain_count++;
    end
    // quiet window for stray flits.
    repeat (20) @(negedge clk);
    missing_count = exp_q.size();
    if (missing_count != 0) begin
      $display("%0d expected output flits never appeared", missing_count);
    end
    $display("flits checked %0d over %0d cycles", checked_count, cycle_count);
    print_counts();
    if (total_errors() == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- noc_error_checker.f
src/noc_config_pkg.sv
src/noc_flit_pkg.sv
src/noc_packet_steer.sv
src/noc_error_responder.sv
src/noc_flit_merger.sv
src/noc_error_checker.sv
verification/noc_clock_gen.sv
verification/noc_error_checker_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module noc_error_checker_tb \
  -f noc_error_checker.f \
  -Mdir obj_dir

sim_output="$(./obj_dir/Vnoc_error_checker_tb 2>&1)" || true
echo "$sim_output"

if grep -qx ">>> PASS" <<< "$sim_output"; then
  exit 0
fi
exit 1
